//--- hdl/mul_pkg.sv
// Shared widths, latency, operation encoding and request/response types for the multiply unit
`default_nettype none

package mul_pkg;

    // Operand and result width
    localparam int xlen = 32;

    // Request tag width, returned unchanged with the result
    localparam int tag_w = 4;

    // Number of delay stages between acceptance and the pipeline output
    localparam int mul_latency = 3;

    // RISC-V M multiply variants
    typedef enum logic [1:0] {
        op_mul    = 2'd0,
        op_mulh   = 2'd1,
        op_mulhsu = 2'd2,
        op_mulhu  = 2'd3
    } mul_op_e;

    // One multiply request, 70 bits
    typedef struct packed {
        logic [tag_w-1:0] tag;
        mul_op_e          op;
        logic [xlen-1:0]  a;
        logic [xlen-1:0]  b;
    } mul_req_t;

    // One multiply response, 36 bits
    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } mul_rsp_t;

endpackage

`default_nettype wire

//--- hdl/shift_register.sv
// Enabled delay line of configurable depth; only the top resetw bits of each stage are reset
`timescale 1ns/10ps
`default_nettype none

module shift_register #(
    parameter int dataw  = 1,
    parameter int resetw = 0,
    parameter int depth  = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic [dataw-1:0] data_in,
    output logic [dataw-1:0] data_out
);

    if (resetw > dataw) begin : g_bad_param
        $error("shift_register: resetw must not exceed dataw");
    end

    if (depth == 0) begin : g_passthru
        // No storage at all, the word goes straight through
        assign data_out = data_in;
    end else begin : g_shift
        if (resetw == dataw) begin : g_full_reset
            logic [depth-1:0][dataw-1:0] stage;

            always_ff @(posedge clk) begin
                if (reset) begin
                    stage <= '0;
                end else if (enable) begin
                    stage[0] <= data_in;
                    for (int i = 1; i < depth; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            assign data_out = stage[depth-1];
        end else if (resetw != 0) begin : g_partial_reset
            // Control bits sit on top and are cleared, the payload below them is not
            logic [depth-1:0][resetw-1:0]       ctrl;
            logic [depth-1:0][dataw-resetw-1:0] payload;

            always_ff @(posedge clk) begin
                if (reset) begin
                    ctrl <= '0;
                end else if (enable) begin
                    ctrl[0] <= data_in[dataw-1 -: resetw];
                    for (int i = 1; i < depth; i++) begin
                        ctrl[i] <= ctrl[i-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (enable) begin
                    payload[0] <= data_in[dataw-resetw-1:0];
                    for (int i = 1; i < depth; i++) begin
                        payload[i] <= payload[i-1];
                    end
                end
            end

            assign data_out = {ctrl[depth-1], payload[depth-1]};
        end else begin : g_no_reset
            logic [depth-1:0][dataw-1:0] stage;

            always_ff @(posedge clk) begin
                if (enable) begin
                    stage[0] <= data_in;
                    for (int i = 1; i < depth; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            assign data_out = stage[depth-1];
        end
    end

endmodule

`default_nettype wire

//--- hdl/mul_pipe.sv
// Fixed-latency multiply pipeline that stalls as a whole when its output is back-pressured
`timescale 1ns/10ps
`default_nettype none

module mul_pipe (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    output logic              req_ready,
    input  mul_pkg::mul_req_t req,
    output logic              pipe_valid,
    input  logic              pipe_ready,
    output mul_pkg::mul_rsp_t pipe_rsp
);

    // Valid must stay the top field so that it lands in the reset part of the delay line
    typedef struct packed {
        logic                      valid;
        logic [mul_pkg::tag_w-1:0] tag;
        mul_pkg::mul_op_e          op;
        logic [2*mul_pkg::xlen-1:0] prod;
    } mul_stage_t;

    logic                              enable;
    logic                              a_signed;
    logic                              b_signed;
    logic signed [mul_pkg::xlen:0]     a_ext;
    logic signed [mul_pkg::xlen:0]     b_ext;
    logic signed [2*mul_pkg::xlen-1:0] product;
    mul_stage_t                        stage_in;
    mul_stage_t                        stage_out;

    // The whole pipe freezes only when a result is waiting and cannot leave
    assign enable    = !(pipe_valid && !pipe_ready);
    assign req_ready = enable;

    // mulh treats both operands as signed, mulhsu only a; mul and mulhu need no sign
    assign a_signed = (req.op == mul_pkg::op_mulh) || (req.op == mul_pkg::op_mulhsu);
    assign b_signed = (req.op == mul_pkg::op_mulh);

    assign a_ext = {a_signed & req.a[mul_pkg::xlen-1], req.a};
    assign b_ext = {b_signed & req.b[mul_pkg::xlen-1], req.b};

    // Both 33-bit operands are sign extended to 64 bits, the low 64 bits of the
    // product are exact for every operation
    assign product = (2*mul_pkg::xlen)'(a_ext) * (2*mul_pkg::xlen)'(b_ext);

    always_comb begin
        stage_in.valid = req_valid && req_ready;
        stage_in.tag   = req.tag;
        stage_in.op    = req.op;
        stage_in.prod  = product;
    end

    shift_register #(
        .dataw  ($bits(mul_stage_t)),
        .resetw (1),
        .depth  (mul_pkg::mul_latency)
    ) i_delay (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (stage_in),
        .data_out (stage_out)
    );

    assign pipe_valid   = stage_out.valid;
    assign pipe_rsp.tag = stage_out.tag;

    // Only mul returns the low half, the three high variants share the upper half
    always_comb begin
        if (stage_out.op == mul_pkg::op_mul) begin
            pipe_rsp.data = stage_out.prod[mul_pkg::xlen-1:0];
        end else begin
            pipe_rsp.data = stage_out.prod[2*mul_pkg::xlen-1:mul_pkg::xlen];
        end
    end

    // A stalled result must stay put until the buffer takes it
    a_rsp_hold: assert property (
        @(posedge clk) disable iff (reset)
        (pipe_valid && !pipe_ready) |=> (pipe_valid && $stable(pipe_rsp))
    ) else $error("mul_pipe: stalled response changed");

endmodule

`default_nettype wire

//--- hdl/elastic_buffer.sv
// Two-entry FIFO between the multiply pipeline and the response port; in_ready is registered
`timescale 1ns/10ps
`default_nettype none

module elastic_buffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  mul_pkg::mul_rsp_t in_data,
    output logic              out_valid,
    input  logic              out_ready,
    output mul_pkg::mul_rsp_t out_data
);

    mul_pkg::mul_rsp_t mem [2];
    logic              rd_ptr;
    logic              wr_ptr;
    logic [1:0]        count;
    logic [1:0]        count_next;
    logic              push;
    logic              pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 2'd1;
        end else if (pop && !push) begin
            count_next = count - 2'd1;
        end
    end

    // Control state with reset
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr   <= 1'b0;
            wr_ptr   <= 1'b0;
            count    <= 2'd0;
            in_ready <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count    <= count_next;
            // Ready comes from a flop so the upstream stall path stays short
            in_ready <= (count_next < 2'd2);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];

    a_count_max: assert property (
        @(posedge clk) disable iff (reset)
        count <= 2'd2
    ) else $error("elastic_buffer: count above two");

    // The oldest entry is presented until it is taken
    a_out_hold: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("elastic_buffer: out_data changed while stalled");

endmodule

`default_nettype wire

//--- hdl/mul_unit.sv
// Top of the multiply unit: the multiply pipeline followed by a two-entry output buffer
`timescale 1ns/10ps
`default_nettype none

module mul_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    output logic              req_ready,
    input  mul_pkg::mul_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output mul_pkg::mul_rsp_t rsp
);

    // Link between the pipeline output and the buffer input
    logic              pipe_valid;
    logic              pipe_ready;
    mul_pkg::mul_rsp_t pipe_rsp;

    mul_pipe i_pipe (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .pipe_valid (pipe_valid),
        .pipe_ready (pipe_ready),
        .pipe_rsp   (pipe_rsp)
    );

    elastic_buffer i_out_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pipe_valid),
        .in_ready  (pipe_ready),
        .in_data   (pipe_rsp),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp)
    );

endmodule

`default_nettype wire

//--- dv/mul_unit_tb.sv
// Self-checking testbench for the multiply unit; corner and random requests are checked by assertions
`timescale 1ns/10ps
`default_nettype none

module mul_unit_tb;

    localparam int n_corner  = 4 * 5 * 5;
    localparam int n_random  = 1060;
    localparam int n_latency = 40;
    // Random response stalls cost about one cycle in four, three cycles per request is ample
    localparam int max_cycles = 3 * (n_corner + n_random + n_latency) + 400;
    // At most five results are held inside the unit and all leave within a few cycles
    localparam int drain_limit = 16;

    logic              clk;
    logic              reset;
    logic              req_valid;
    logic              req_ready;
    mul_pkg::mul_req_t req;
    logic              rsp_valid;
    logic              rsp_ready;
    mul_pkg::mul_rsp_t rsp;

    integer                    seed;
    string                     test_name;
    logic                      ready_random;
    logic                      fixed_lat;
    logic                      after_reset = 1'b0;
    logic                      head_valid = 1'b0;
    mul_pkg::mul_rsp_t         head;
    mul_pkg::mul_rsp_t         rsp_prev;
    mul_pkg::mul_rsp_t         exp_q [$];
    logic [mul_pkg::tag_w-1:0] next_tag;
    int                        value_errors = 0;
    int                        protocol_errors = 0;
    int                        cycles = 0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    mul_unit i_dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    // Zero, one, minus one, most negative and largest positive
    function automatic logic [31:0] corner_value(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    function automatic logic [31:0] expected_result(input mul_pkg::mul_op_e op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        prod;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        // A signed times an unsigned 32-bit value always fits in 64 signed bits
        case (op)
            mul_pkg::op_mulh:   prod = sa * sb;
            mul_pkg::op_mulhsu: prod = sa * $signed(ub);
            default:            prod = ua * ub;
        endcase
        if (op == mul_pkg::op_mul) begin
            return prod[31:0];
        end
        return prod[63:32];
    endfunction

    task automatic step();
        logic [31:0] rnd;
        @(posedge clk);
        #1;
        rnd = $random(seed);
        if (ready_random) begin
            rsp_ready = (rnd[1:0] != 2'd0);
        end else begin
            rsp_ready = 1'b1;
        end
    endtask

    task automatic send_req(input mul_pkg::mul_op_e op, input logic [31:0] a,
                            input logic [31:0] b);
        logic accepted;
        req_valid = 1'b1;
        req.tag   = next_tag;
        req.op    = op;
        req.a     = a;
        req.b     = b;
        accepted  = 1'b0;
        while (!accepted) begin
            // req_ready only moves on a rising edge, mid-cycle it is settled
            @(negedge clk);
            accepted = req_ready;
            step();
        end
        req_valid = 1'b0;
        next_tag  = next_tag + 1'b1;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            step();
            waited++;
        end
    endtask

    initial begin : stimulus
        logic [31:0] rnd;
        logic [31:0] op_a;
        logic [31:0] op_b;
        seed         = 78799;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b0;
        ready_random = 1'b0;
        fixed_lat    = 1'b0;
        next_tag     = '0;
        test_name    = "reset";
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name    = "corner_ops";
        ready_random = 1'b1;
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    send_req(mul_pkg::mul_op_e'(op[1:0]), corner_value(i), corner_value(j));
                end
            end
        end

        test_name = "random_ops";
        for (int n = 0; n < n_random; n++) begin
            rnd  = $random(seed);
            op_a = $random(seed);
            op_b = $random(seed);
            send_req(mul_pkg::mul_op_e'(rnd[1:0]), op_a, op_b);
            if (rnd[4:2] == 3'd0) begin
                step();
            end
        end

        // Empty the unit first so that no leftover entry delays the timed requests
        test_name    = "fixed_latency";
        ready_random = 1'b0;
        drain();
        repeat (2) step();
        fixed_lat = 1'b1;
        for (int n = 0; n < n_latency; n++) begin
            rnd  = $random(seed);
            op_a = $random(seed);
            op_b = $random(seed);
            send_req(mul_pkg::mul_op_e'(rnd[1:0]), op_a, op_b);
        end
        fixed_lat = 1'b0;
        drain();

        test_name = "final";
        repeat (4) step();
        if (exp_q.size() != 0) begin
            $display("Error: %0d responses never came back", exp_q.size());
            protocol_errors++;
        end
        $display("Checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Reference queue of accepted requests; head is the next response due
    always @(posedge clk) begin : scoreboard
        mul_pkg::mul_rsp_t item;
        after_reset <= reset;
        rsp_prev    <= rsp;
        if (reset) begin
            exp_q.delete();
        end else begin
            if (req_valid && req_ready) begin
                item.tag  = req.tag;
                item.data = expected_result(req.op, req.a, req.b);
                exp_q.push_back(item);
            end
            if (rsp_valid && rsp_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
        end
        head_valid <= (exp_q.size() != 0);
        if (exp_q.size() != 0) begin
            head <= exp_q[0];
        end
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("Error: run did not finish within %0d cycles", max_cycles);
            $display("Checks done: %0d value errors, %0d protocol errors",
                     value_errors, protocol_errors);
            $display("Test failed");
            $finish;
        end
    end

    a_rsp_match: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_valid && rsp_ready && head_valid) |-> (rsp == head)
    ) else begin
        value_errors++;
        $display("Error: test %s expected tag %0h data %08h, actual tag %0h data %08h",
                 test_name, $sampled(head.tag), $sampled(head.data),
                 $sampled(rsp.tag), $sampled(rsp.data));
    end

    a_rsp_extra: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_valid && rsp_ready) |-> head_valid
    ) else begin
        protocol_errors++;
        $display("Error: in test %s a response came back with no request outstanding",
                 test_name);
    end

    a_rsp_hold: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else begin
        value_errors++;
        $display("Error: test %s stalled response expected %09h, actual %09h valid %b",
                 test_name, $sampled(rsp_prev), $sampled(rsp), $sampled(rsp_valid));
    end

    a_reset_state: assert property (
        @(posedge clk)
        after_reset |-> (!rsp_valid && req_ready)
    ) else begin
        value_errors++;
        $display("Error: test %s expected rsp_valid 0 req_ready 1, actual %b %b",
                 test_name, $sampled(rsp_valid), $sampled(req_ready));
    end

    // With the response side always ready, each result leaves exactly four cycles later
    a_latency: assert property (
        @(posedge clk) disable iff (reset)
        $past(fixed_lat && req_valid && req_ready, 4) |-> (rsp_valid && rsp_ready)
    ) else begin
        protocol_errors++;
        $display("Error: in test %s a response did not transfer four cycles after acceptance",
                 test_name);
    end

endmodule

`default_nettype wire

//--- all.f
hdl/mul_pkg.sv
hdl/shift_register.sv
hdl/mul_pipe.sv
hdl/elastic_buffer.sv
hdl/mul_unit.sv
dv/mul_unit_tb.sv

//--- run.sh
#!/bin/sh
# Builds the multiply unit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module mul_unit_tb -o mul_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

./obj_dir/mul_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
